//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// memory depths in words.
`define IM_DEPTH 256
`define DM_DEPTH 256

// primary opcodes.
`define OP_ALU  6'h20
`define OP_ADDI 6'h28
`define OP_LWI  6'h02
`define OP_SWI  6'h0a
`define OP_J    6'h24

// base sub-opcodes for OP_ALU.
`define SUB_ADD 5'h00
`define SUB_SUB 5'h01
`define SUB_AND 5'h02
`define SUB_XOR 5'h03
`define SUB_OR  5'h04

// add r0, r0, r0.
`define NOP_WORD {`OP_ALU, 5'd0, 5'd0, 5'd0, 6'd0, `SUB_ADD}

`endif

//--- src/cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [ 4:0] reg_addr_t;
	typedef logic [ 5:0] opcode_t;
	typedef logic [ 4:0] sub_op_t;
	typedef logic [13:0] imm14_t;
	typedef logic [23:0] imm24_t;

	// word index into the instruction memory.
	typedef logic [$clog2(`IM_DEPTH)-1:0] pc_t;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

endpackage

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic   clock,
	input  logic   rst,
	input  logic   run,
	input  logic   im_write,
	input  pc_t    im_addr,
	input  word_t  im_wdata,
	input  logic   jump_taken,
	input  imm24_t jump_target,
	output word_t  fetch_instr,
	output pc_t    pc
);

	word_t im [`IM_DEPTH];

	// program load port.
	always_ff @(posedge clock) begin
		if (im_write)
			im[im_addr] <= im_wdata;
	end

	assign fetch_instr = im[pc]; // async read at the pc.

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
		end else if (run) begin
			if (jump_taken)
				pc <= jump_target[$bits(pc_t)-1:0];
			else
				pc <= pc + 1'b1;
		end
	end

	// the program is only loaded while the core is stopped.
	a_load_stopped: assert property (
		@(posedge clock) disable iff (rst)
		im_write |-> !run
	);

endmodule

`default_nettype wire

//--- src/decode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module decode_ctrl import cpu_pkg::*; (
	input  word_t     instr,
	output opcode_t   opcode,
	output sub_op_t   sub_op_base,
	output imm14_t    imm_14bit,
	output imm24_t    imm_24bit,
	output reg_addr_t ra_addr,
	output reg_addr_t rt_addr,
	output reg_addr_t rb_addr,
	output alu_op_t   alu_op,
	output logic      select_alu_imm,
	output wb_sel_t   select_write_reg,
	output logic      do_dm_read,
	output logic      do_dm_write,
	output logic      do_reg_write,
	output logic      do_jump
);

	assign opcode      = instr[31:26];
	assign rt_addr     = instr[25:21];
	assign ra_addr     = instr[20:16];
	assign sub_op_base = instr[4:0];
	assign imm_14bit   = instr[13:0];
	assign imm_24bit   = instr[23:0];

	// second read port takes rt on a store, for the store data.
	assign rb_addr = (opcode == `OP_SWI) ? instr[25:21] : instr[15:11];

	always_comb begin
		alu_op           = ALU_ADD;
		select_alu_imm   = 1'b0;
		select_write_reg = WB_ALU;
		do_dm_read       = 1'b0;
		do_dm_write      = 1'b0;
		do_reg_write     = 1'b0;
		do_jump          = 1'b0;
		case (opcode)
			`OP_ALU: begin
				do_reg_write = 1'b1;
				case (sub_op_base)
					`SUB_ADD: alu_op = ALU_ADD;
					`SUB_SUB: alu_op = ALU_SUB;
					`SUB_AND: alu_op = ALU_AND;
					`SUB_OR:  alu_op = ALU_OR;
					`SUB_XOR: alu_op = ALU_XOR;
					default:  do_reg_write = 1'b0; // unknown sub-op, no effect.
				endcase
			end
			`OP_ADDI: begin
				select_alu_imm = 1'b1;
				do_reg_write   = 1'b1;
			end
			`OP_LWI: begin
				select_alu_imm   = 1'b1;
				select_write_reg = WB_MEM;
				do_dm_read       = 1'b1;
				do_reg_write     = 1'b1;
			end
			`OP_SWI: begin
				select_alu_imm = 1'b1; // address is ra plus imm.
				do_dm_write    = 1'b1;
			end
			`OP_J: do_jump = 1'b1;
			default: ; // runs as a nop.
		endcase
	end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	output word_t     ra_data,
	output word_t     rb_data,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata
);

	word_t regs [32];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired to zero.
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

//--- src/pipe_walls.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module pipe_walls import cpu_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      run,
	input  logic      flush,

	input  word_t     fetch_instr,
	output word_t     id_instr,

	input  word_t     ra_data,
	input  word_t     rt_data,
	input  word_t     rb_data,
	input  alu_op_t   alu_op,
	input  imm14_t    imm_14bit,
	input  imm24_t    imm_24bit,
	input  logic      select_alu_imm,
	input  wb_sel_t   select_write_reg,
	input  reg_addr_t rt_addr,
	input  logic      do_dm_read,
	input  logic      do_dm_write,
	input  logic      do_reg_write,
	input  logic      do_jump,

	output word_t     ex_ra_data,
	output word_t     ex_rt_data,
	output word_t     ex_rb_data,
	output alu_op_t   ex_alu_op,
	output imm14_t    ex_imm_14bit,
	output imm24_t    ex_imm_24bit,
	output logic      ex_select_alu_imm,
	output wb_sel_t   ex_select_write_reg,
	output reg_addr_t ex_rt_addr,
	output logic      ex_do_dm_read,
	output logic      ex_do_dm_write,
	output logic      ex_do_reg_write,
	output logic      ex_do_jump
);

	// IF/ID wall.
	always_ff @(posedge clock) begin
		if (rst || flush)
			id_instr <= `NOP_WORD;
		else if (run)
			id_instr <= fetch_instr;
	end

	// ID/EX strobes, dropped on a flush.
	always_ff @(posedge clock) begin
		if (rst || flush) begin
			ex_do_dm_read   <= 1'b0;
			ex_do_dm_write  <= 1'b0;
			ex_do_reg_write <= 1'b0;
			ex_do_jump      <= 1'b0;
		end else if (run) begin
			ex_do_dm_read   <= do_dm_read;
			ex_do_dm_write  <= do_dm_write;
			ex_do_reg_write <= do_reg_write;
			ex_do_jump      <= do_jump;
		end
	end

	// ID/EX payload.
	always_ff @(posedge clock) begin
		if (run) begin
			ex_ra_data          <= ra_data;
			ex_rt_data          <= rt_data;
			ex_rb_data          <= rb_data;
			ex_alu_op           <= alu_op;
			ex_imm_14bit        <= imm_14bit;
			ex_imm_24bit        <= imm_24bit;
			ex_select_alu_imm   <= select_alu_imm;
			ex_select_write_reg <= select_write_reg;
			ex_rt_addr          <= rt_addr;
		end
	end

	// one kind of side effect per instruction.
	a_one_effect: assert property (
		@(posedge clock) disable iff (rst)
		$onehot0({ex_do_dm_write, ex_do_reg_write, ex_do_jump})
	);

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module exec_unit import cpu_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      run,

	input  word_t     ex_ra_data,
	input  word_t     ex_rt_data,
	input  word_t     ex_rb_data,
	input  alu_op_t   ex_alu_op,
	input  imm14_t    ex_imm_14bit,
	input  imm24_t    ex_imm_24bit,
	input  logic      ex_select_alu_imm,
	input  wb_sel_t   ex_select_write_reg,
	input  reg_addr_t ex_rt_addr,
	input  logic      ex_do_dm_read,
	input  logic      ex_do_dm_write,
	input  logic      ex_do_reg_write,
	input  logic      ex_do_jump,

	output logic      reg_write,
	output reg_addr_t reg_waddr,
	output word_t     reg_wdata,
	output logic      dm_write,
	output pc_t       dm_addr,
	output word_t     dm_wdata,
	output logic      jump_taken,
	output imm24_t    jump_target
);

	word_t dm [`DM_DEPTH];
	word_t imm_ext;
	word_t op_b;
	word_t alu_res;
	word_t dm_rdata;

	assign imm_ext = {{18{ex_imm_14bit[13]}}, ex_imm_14bit};
	assign op_b    = ex_select_alu_imm ? imm_ext : ex_rb_data;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_res = ex_ra_data - op_b;
			ALU_AND: alu_res = ex_ra_data & op_b;
			ALU_OR:  alu_res = ex_ra_data | op_b;
			ALU_XOR: alu_res = ex_ra_data ^ op_b;
			default: alu_res = ex_ra_data + op_b; // add, addi, load/store address.
		endcase
	end

	assign dm_addr  = alu_res[$bits(pc_t)-1:0]; // word address.
	assign dm_rdata = ex_do_dm_read ? dm[dm_addr] : '0;

	always_ff @(posedge clock) begin
		if (dm_write)
			dm[dm_addr] <= dm_wdata;
	end

	assign reg_write = run & ex_do_reg_write;
	assign reg_waddr = ex_rt_addr;
	assign reg_wdata = (ex_select_write_reg == WB_MEM) ? dm_rdata : alu_res;

	assign dm_write = run & ex_do_dm_write;
	assign dm_wdata = ex_rt_data;

	assign jump_taken  = run & ex_do_jump;
	assign jump_target = ex_imm_24bit;

	// the flush must kill whatever follows a jump.
	a_jump_bubble: assert property (
		@(posedge clock) disable iff (rst)
		jump_taken |=> !reg_write && !dm_write && !jump_taken
	);

endmodule

`default_nettype wire

//--- src/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      run,
	input  logic      im_write,
	input  pc_t       im_addr,
	input  word_t     im_wdata,
	output pc_t       pc,
	output logic      reg_write,
	output reg_addr_t reg_waddr,
	output word_t     reg_wdata,
	output logic      dm_write,
	output pc_t       dm_addr,
	output word_t     dm_wdata
);

	word_t     fetch_instr, id_instr;
	logic      jump_taken;
	imm24_t    jump_target;

	imm14_t    imm_14bit, ex_imm_14bit;
	imm24_t    imm_24bit, ex_imm_24bit;
	reg_addr_t ra_addr, rt_addr, rb_addr, ex_rt_addr;
	alu_op_t   alu_op, ex_alu_op;
	logic      select_alu_imm, ex_select_alu_imm;
	wb_sel_t   select_write_reg, ex_select_write_reg;
	logic      do_dm_read, do_dm_write, do_reg_write, do_jump;
	logic      ex_do_dm_read, ex_do_dm_write, ex_do_reg_write, ex_do_jump;

	word_t     ra_data, rb_data;
	word_t     ex_ra_data, ex_rt_data, ex_rb_data;

	fetch_unit u_fetch (
		.clock(clock), .rst(rst), .run(run),
		.im_write(im_write), .im_addr(im_addr), .im_wdata(im_wdata),
		.jump_taken(jump_taken), .jump_target(jump_target),
		.fetch_instr(fetch_instr), .pc(pc)
	);

	decode_ctrl u_decode (
		.instr(id_instr), .opcode(), .sub_op_base(),
		.imm_14bit(imm_14bit), .imm_24bit(imm_24bit),
		.ra_addr(ra_addr), .rt_addr(rt_addr), .rb_addr(rb_addr),
		.alu_op(alu_op), .select_alu_imm(select_alu_imm),
		.select_write_reg(select_write_reg),
		.do_dm_read(do_dm_read), .do_dm_write(do_dm_write),
		.do_reg_write(do_reg_write), .do_jump(do_jump)
	);

	// port b carries rt for stores and rb otherwise.
	reg_file u_regs (
		.clock(clock), .rst(rst),
		.ra_addr(ra_addr), .rb_addr(rb_addr),
		.ra_data(ra_data), .rb_data(rb_data),
		.we(reg_write), .waddr(reg_waddr), .wdata(reg_wdata)
	);

	pipe_walls u_walls (
		.clock(clock), .rst(rst), .run(run), .flush(jump_taken),
		.fetch_instr(fetch_instr), .id_instr(id_instr),
		.ra_data(ra_data), .rt_data(rb_data), .rb_data(rb_data),
		.alu_op(alu_op), .imm_14bit(imm_14bit), .imm_24bit(imm_24bit),
		.select_alu_imm(select_alu_imm), .select_write_reg(select_write_reg),
		.rt_addr(rt_addr), .do_dm_read(do_dm_read), .do_dm_write(do_dm_write),
		.do_reg_write(do_reg_write), .do_jump(do_jump),
		.ex_ra_data(ex_ra_data), .ex_rt_data(ex_rt_data), .ex_rb_data(ex_rb_data),
		.ex_alu_op(ex_alu_op), .ex_imm_14bit(ex_imm_14bit), .ex_imm_24bit(ex_imm_24bit),
		.ex_select_alu_imm(ex_select_alu_imm), .ex_select_write_reg(ex_select_write_reg),
		.ex_rt_addr(ex_rt_addr), .ex_do_dm_read(ex_do_dm_read),
		.ex_do_dm_write(ex_do_dm_write), .ex_do_reg_write(ex_do_reg_write),
		.ex_do_jump(ex_do_jump)
	);

	exec_unit u_exec (
		.clock(clock), .rst(rst), .run(run),
		.ex_ra_data(ex_ra_data), .ex_rt_data(ex_rt_data), .ex_rb_data(ex_rb_data),
		.ex_alu_op(ex_alu_op), .ex_imm_14bit(ex_imm_14bit), .ex_imm_24bit(ex_imm_24bit),
		.ex_select_alu_imm(ex_select_alu_imm), .ex_select_write_reg(ex_select_write_reg),
		.ex_rt_addr(ex_rt_addr), .ex_do_dm_read(ex_do_dm_read),
		.ex_do_dm_write(ex_do_dm_write), .ex_do_reg_write(ex_do_reg_write),
		.ex_do_jump(ex_do_jump),
		.reg_write(reg_write), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
		.dm_write(dm_write), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
		.jump_taken(jump_taken), .jump_target(jump_target)
	);

endmodule

`default_nettype wire

//--- verif/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int NT = 6;
	localparam int PROG_WORDS = 20; // program plus nop padding.
	localparam int RUN_CYCLES = 18;
	localparam int MAX_EV = 8;
	localparam int FIRST_TICK = 3; // raising edge, then two edges to write-back.
	// reset, load, start, mid-run reset, run and tail.
	localparam int CYCLES_PER_TEST = 11 + PROG_WORDS + 1 + 1 + 6 + RUN_CYCLES + 1;
	localparam int TIMEOUT_NS = NT * CYCLES_PER_TEST * 20 + 1000;

	logic clock;
	logic rst;
	logic run;
	logic im_write;
	pc_t im_addr;
	word_t im_wdata;
	pc_t pc;
	logic reg_write;
	reg_addr_t reg_waddr;
	word_t reg_wdata;
	logic dm_write;
	pc_t dm_addr;
	word_t dm_wdata;

	string names [NT];
	word_t prog [NT][16];
	logic mid_rst [NT];
	pc_t exp_pc [NT];
	int exp_n [NT];
	logic exp_kind [NT][MAX_EV]; // 0 register write, 1 store.
	int exp_addr [NT][MAX_EV];
	word_t exp_val [NT][MAX_EV];

	logic ev_kind [$];
	int ev_addr [$];
	word_t ev_val [$];
	int run_ticks;
	int first_tick;
	int errors;
	int passed;
	logic [31:0] rng;

	cpu_top UUT (
		.clock(clock), .rst(rst), .run(run),
		.im_write(im_write), .im_addr(im_addr), .im_wdata(im_wdata),
		.pc(pc), .reg_write(reg_write), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
		.dm_write(dm_write), .dm_addr(dm_addr), .dm_wdata(dm_wdata)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t sign_extend(input imm14_t v);
		return word_t'(32'($signed(v)));
	endfunction

	function automatic word_t addi_word(input reg_addr_t rt, input reg_addr_t ra, input imm14_t imm);
		return {`OP_ADDI, rt, ra, 2'b00, imm};
	endfunction

	function automatic word_t alu_word(input sub_op_t sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb);
		return {`OP_ALU, rt, ra, rb, 6'd0, sub};
	endfunction

	function automatic word_t lwi_word(input reg_addr_t rt, input reg_addr_t ra, input imm14_t imm);
		return {`OP_LWI, rt, ra, 2'b00, imm};
	endfunction

	function automatic word_t swi_word(input reg_addr_t rt, input reg_addr_t ra, input imm14_t imm);
		return {`OP_SWI, rt, ra, 2'b00, imm};
	endfunction

	function automatic word_t jump_word(input imm24_t target);
		return {`OP_J, 2'b00, target};
	endfunction

	task automatic add_event(input int t, input logic kind, input int addr, input word_t val);
		exp_kind[t][exp_n[t]] = kind;
		exp_addr[t][exp_n[t]] = addr;
		exp_val[t][exp_n[t]] = val;
		exp_n[t] = exp_n[t] + 1;
	endtask

	function automatic imm14_t next_imm();
		rng = xorshift(rng);
		return rng[13:0];
	endfunction

	task automatic build_tests();
		imm14_t i1, i2, i3, i4, i5;
		word_t a, b, v, r3;
		for (int t = 0; t < NT; t++) begin
			exp_n[t] = 0;
			mid_rst[t] = 1'b0;
			exp_pc[t] = pc_t'(RUN_CYCLES); // one word per running cycle.
			for (int k = 0; k < 16; k++)
				prog[t][k] = `NOP_WORD;
		end

		// addi chains with random signs.
		names[0] = "addi_sum";
		i1 = next_imm();
		i2 = next_imm();
		i3 = next_imm();
		i4 = next_imm();
		i5 = next_imm();
		prog[0][0] = addi_word(5'd1, 5'd0, i1);
		prog[0][1] = addi_word(5'd2, 5'd0, i2);
		prog[0][2] = addi_word(5'd3, 5'd1, i3);
		prog[0][3] = addi_word(5'd4, 5'd2, i4);
		prog[0][4] = addi_word(5'd5, 5'd3, i5);
		r3 = sign_extend(i1) + sign_extend(i3);
		add_event(0, 1'b0, 1, sign_extend(i1));
		add_event(0, 1'b0, 2, sign_extend(i2));
		add_event(0, 1'b0, 3, r3);
		add_event(0, 1'b0, 4, sign_extend(i2) + sign_extend(i4));
		add_event(0, 1'b0, 5, r3 + sign_extend(i5));

		names[1] = "alu_ops";
		i1 = next_imm();
		i2 = next_imm();
		a = sign_extend(i1);
		b = sign_extend(i2);
		prog[1][0] = addi_word(5'd1, 5'd0, i1);
		prog[1][1] = addi_word(5'd2, 5'd0, i2);
		prog[1][3] = alu_word(`SUB_ADD, 5'd3, 5'd1, 5'd2);
		prog[1][4] = alu_word(`SUB_SUB, 5'd4, 5'd1, 5'd2);
		prog[1][5] = alu_word(`SUB_AND, 5'd5, 5'd1, 5'd2);
		prog[1][6] = alu_word(`SUB_OR, 5'd6, 5'd1, 5'd2);
		prog[1][7] = alu_word(`SUB_XOR, 5'd7, 5'd1, 5'd2);
		add_event(1, 1'b0, 1, a);
		add_event(1, 1'b0, 2, b);
		add_event(1, 1'b0, 3, a + b);
		add_event(1, 1'b0, 4, a - b);
		add_event(1, 1'b0, 5, a & b);
		add_event(1, 1'b0, 6, a | b);
		add_event(1, 1'b0, 7, a ^ b);

		// store then load back, base kept small and positive.
		names[2] = "store_load";
		i1 = next_imm();
		i1 = {8'd0, i1[5:0]};
		i2 = next_imm();
		i3 = next_imm();
		i3 = {10'd0, i3[3:0]};
		v = sign_extend(i2);
		prog[2][0] = addi_word(5'd1, 5'd0, i1);
		prog[2][1] = addi_word(5'd2, 5'd0, i2);
		prog[2][3] = swi_word(5'd2, 5'd1, i3);
		prog[2][5] = lwi_word(5'd3, 5'd1, i3);
		add_event(2, 1'b0, 1, sign_extend(i1));
		add_event(2, 1'b0, 2, v);
		add_event(2, 1'b1, int'(i1[7:0] + i3[7:0]), v);
		add_event(2, 1'b0, 3, v);

		names[3] = "jump_skip";
		i1 = next_imm();
		i2 = next_imm();
		i5 = next_imm();
		prog[3][0] = addi_word(5'd1, 5'd0, i1);
		prog[3][1] = jump_word(24'd5);
		prog[3][2] = addi_word(5'd2, 5'd0, i2);
		prog[3][3] = addi_word(5'd3, 5'd0, i2);
		prog[3][5] = addi_word(5'd5, 5'd1, i5);
		exp_pc[3] = pc_t'(RUN_CYCLES + 1); // target 5 replaces pc 4.
		add_event(3, 1'b0, 1, sign_extend(i1));
		add_event(3, 1'b0, 5, sign_extend(i1) + sign_extend(i5));

		names[4] = "r0_zero";
		i1 = next_imm() | 14'd1; // nonzero so the r0 write is visible.
		i2 = next_imm();
		prog[4][0] = addi_word(5'd0, 5'd0, i1);
		prog[4][2] = addi_word(5'd1, 5'd0, i2);
		prog[4][4] = alu_word(`SUB_ADD, 5'd2, 5'd1, 5'd0);
		add_event(4, 1'b0, 0, sign_extend(i1));
		add_event(4, 1'b0, 1, sign_extend(i2));
		add_event(4, 1'b0, 2, sign_extend(i2));

		names[5] = "mid_reset";
		mid_rst[5] = 1'b1;
		i1 = next_imm();
		i2 = next_imm();
		i3 = next_imm();
		prog[5][0] = addi_word(5'd1, 5'd0, i1);
		prog[5][1] = addi_word(5'd2, 5'd0, i2);
		prog[5][2] = addi_word(5'd3, 5'd1, i3);
		add_event(5, 1'b0, 1, sign_extend(i1));
		add_event(5, 1'b0, 2, sign_extend(i2));
		add_event(5, 1'b0, 3, sign_extend(i1) + sign_extend(i3));
	endtask

	// nop bubbles write zero to r0 and are not counted.
	always @(negedge clock) begin
		if (run)
			run_ticks = run_ticks + 1;
		else
			run_ticks = 0;
		if (reg_write && !(reg_waddr == '0 && reg_wdata == '0)) begin
			if (ev_kind.size() == 0)
				first_tick = run_ticks;
			ev_kind.push_back(1'b0);
			ev_addr.push_back(int'(reg_waddr));
			ev_val.push_back(reg_wdata);
		end
		if (dm_write) begin
			if (ev_kind.size() == 0)
				first_tick = run_ticks;
			ev_kind.push_back(1'b1);
			ev_addr.push_back(int'(dm_addr));
			ev_val.push_back(dm_wdata);
		end
	end

	task automatic reset_core();
		@(posedge clock);
		rst <= 1'b1;
		run <= 1'b0;
		repeat (10) @(posedge clock);
		rst <= 1'b0;
	endtask

	task automatic load_program(input int t);
		for (int k = 0; k < PROG_WORDS; k++) begin
			@(posedge clock);
			im_write <= 1'b1;
			im_addr <= pc_t'(k);
			im_wdata <= (k < 16) ? prog[t][k] : `NOP_WORD;
		end
		@(posedge clock);
		im_write <= 1'b0;
	endtask

	task automatic run_test(input int t);
		int bad;
		string kname;
		string aname;
		bad = 0;
		reset_core();
		load_program(t);
		ev_kind.delete();
		ev_addr.delete();
		ev_val.delete();
		first_tick = -1;
		@(posedge clock);
		run <= 1'b1;
		if (mid_rst[t]) begin
			@(posedge clock);
			rst <= 1'b1; // reset while running.
			repeat (4) @(posedge clock);
			rst <= 1'b0;
			run <= 1'b0;
			if (ev_kind.size() != 0) begin
				$display("%s: write events seen during reset", names[t]);
				bad++;
			end
			@(posedge clock);
			run <= 1'b1;
		end
		repeat (RUN_CYCLES) @(posedge clock);
		run <= 1'b0;
		@(posedge clock);

		for (int i = 0; i < exp_n[t]; i++) begin
			kname = exp_kind[t][i] ? "store" : "reg";
			if (i >= ev_kind.size()) begin
				$display("%s: expected %s event %0d never happened", names[t], kname, i);
				bad++;
			end else if (ev_kind[i] != exp_kind[t][i] || ev_addr[i] != exp_addr[t][i]
					|| ev_val[i] != exp_val[t][i]) begin
				aname = ev_kind[i] ? "store" : "reg";
				$display("Error %s: event %0d expected %s %0d = %h, actual %s %0d = %h",
					names[t], i, kname, exp_addr[t][i], exp_val[t][i],
					aname, ev_addr[i], ev_val[i]);
				bad++;
			end
		end
		if (ev_kind.size() > exp_n[t]) begin
			$display("%s: %0d write events more than expected", names[t],
				ev_kind.size() - exp_n[t]);
			bad++;
		end
		if (first_tick != FIRST_TICK) begin
			$display("Error %s: first write-back tick expected %0d, actual %0d",
				names[t], FIRST_TICK, first_tick);
			bad++;
		end
		if (pc != exp_pc[t]) begin
			$display("Error %s: pc expected %0d, actual %0d", names[t], exp_pc[t], pc);
			bad++;
		end

		if (bad == 0) begin
			$display("test %s ok", names[t]);
			passed++;
		end else begin
			$display("test %s FAILED with %0d problems", names[t], bad);
		end
		errors = errors + bad;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish in time");
		$display("Regression failed");
		$finish;
	end

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		im_write = 1'b0;
		im_addr = '0;
		im_wdata = '0;
		run_ticks = 0;
		first_tick = -1;
		errors = 0;
		passed = 0;
		rng = 32'h4256;
		build_tests();
		for (int t = 0; t < NT; t++)
			run_test(t);
		$display("%0d of %0d tests passed, %0d failed checks", passed, NT, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_ctrl.sv
src/reg_file.sv
src/pipe_walls.sv
src/exec_unit.sv
src/cpu_top.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log.
verilator --binary --timing --assert --top-module cpu_tb -o cpu_sim -f all.f > build.log 2>&1 \
	|| { cat build.log; echo "compile error"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 ; cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log \
	&& exit 0 || exit 1
